// File: verilog/clockOverlay_defines.svh
`ifndef CLOCK_OVERLAY_DEFINES_SVH
`define CLOCK_OVERLAY_DEFINES_SVH

// Character cell size in pixels
`define GLYPH_W            8
`define GLYPH_H            16
`define NUM_SLOTS          22

// Top rows of the character windows
`define TIME_Y             10'd240
`define DAY_Y              10'd434
`define MONTH_Y            10'd450
`define YEAR_Y             10'd418
`define WEEK_Y             10'd16

// Left edges of the character windows
`define HOUR_TENS_X        10'd295
`define HOUR_ONES_X        10'd303
`define MIN_TENS_X         10'd319
`define MIN_ONES_X         10'd327
`define SEC_TENS_X         10'd342
`define SEC_ONES_X         10'd350
`define DAY_TENS_X         10'd591
`define DAY_ONES_X         10'd599
`define MONTH_TENS_X       10'd607
`define MONTH_ONES_X       10'd615
`define CENTURY_X          10'd583  // Four cells of "20" and the year digits
`define LABEL_X            10'd287  // Six cells spelling "SEMANA"
`define WEEK_TENS_X        10'd343
`define WEEK_ONES_X        10'd351

// Colours and fixed character codes
`define TEXT_COLOR         4'd2
`define BLANK_CHAR         7'h0A
`define CHAR_2             7'h32
`define CHAR_0             7'h30
`define CHAR_S             7'h53
`define CHAR_E             7'h45
`define CHAR_M             7'h4D
`define CHAR_A             7'h41
`define CHAR_N             7'h4E

// Last row and colour of each background band
`define BAND0_LAST         10'd140
`define BAND0_COLOR        4'd0
`define BAND1_LAST         10'd151
`define BAND1_COLOR        4'd1
`define BAND2_LAST         10'd338
`define BAND2_COLOR        4'd3
`define BAND3_LAST         10'd348
`define BAND3_COLOR        4'd1
`define BAND4_LAST         10'd351
`define BAND4_COLOR        4'd0
`define BAND5_LAST         10'd353
`define BAND5_COLOR        4'd1
`define BAND6_LAST         10'd472
`define BAND6_COLOR        4'd0
`define BAND7_LAST         10'd480
`define BAND7_COLOR        4'd2
`define BAND_OUT_COLOR     4'd0

`endif

// File: verilog/clockOverlayPkg.sv
package clockOverlayPkg;

  // Screen x or y coordinate
  typedef logic [9:0] pixCoordT;

  // ASCII code forming the upper part of the font-ROM address
  typedef logic [6:0] charCodeT;

  // Row inside a 16-row glyph
  typedef logic [3:0] glyphRowT;

  // Font-ROM address with the code above the row
  typedef logic [10:0] romAddrT;

  // Palette index
  typedef logic [3:0] colorIdxT;

  // Character slot number from 0 to 21
  typedef logic [4:0] slotIdT;

endpackage

// File: verilog/fieldLocator.sv
`timescale 1ns/1ns
`include "clockOverlay_defines.svh"

module fieldLocator (
  input  clockOverlayPkg::pixCoordT pixelX,
  input  clockOverlayPkg::pixCoordT pixelY,
  output logic                      slotHit,
  output clockOverlayPkg::slotIdT   slotId,
  output clockOverlayPkg::glyphRowT glyphRow
);

  import clockOverlayPkg::*;

  localparam pixCoordT CELL_W = pixCoordT'(`GLYPH_W);
  localparam pixCoordT CELL_H = pixCoordT'(`GLYPH_H);

  // Left edge of every slot, indexed by slot number
  localparam pixCoordT SLOT_X [`NUM_SLOTS] = '{
    `HOUR_TENS_X, `HOUR_ONES_X,
    `MIN_TENS_X, `MIN_ONES_X,
    `SEC_TENS_X, `SEC_ONES_X,
    `DAY_TENS_X, `DAY_ONES_X,
    `MONTH_TENS_X, `MONTH_ONES_X,
    `CENTURY_X,                            // "2"
    `CENTURY_X + CELL_W,                   // "0"
    `CENTURY_X + 2 * CELL_W,               // Year tens
    `CENTURY_X + 3 * CELL_W,               // Year ones
    `LABEL_X,
    `LABEL_X + CELL_W,
    `LABEL_X + 2 * CELL_W,
    `LABEL_X + 3 * CELL_W,
    `LABEL_X + 4 * CELL_W,
    `LABEL_X + 5 * CELL_W,
    `WEEK_TENS_X, `WEEK_ONES_X
  };

  // Top row of every slot
  localparam pixCoordT SLOT_Y [`NUM_SLOTS] = '{
    `TIME_Y, `TIME_Y, `TIME_Y, `TIME_Y, `TIME_Y, `TIME_Y,
    `DAY_Y, `DAY_Y,
    `MONTH_Y, `MONTH_Y,
    `YEAR_Y, `YEAR_Y, `YEAR_Y, `YEAR_Y,
    `WEEK_Y, `WEEK_Y, `WEEK_Y, `WEEK_Y, `WEEK_Y, `WEEK_Y,
    `WEEK_Y, `WEEK_Y
  };

  always_comb begin
    pixCoordT rowOffset;
    rowOffset = '0;
    slotHit   = 1'b0;
    slotId    = '0;
    // Scan downwards so that the lowest-numbered hit is the one left standing
    for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
      if ((pixelX >= SLOT_X[i]) && (pixelX < SLOT_X[i] + CELL_W) &&
          (pixelY >= SLOT_Y[i]) && (pixelY < SLOT_Y[i] + CELL_H)) begin
        slotHit   = 1'b1;
        slotId    = slotIdT'(i);
        rowOffset = pixelY - SLOT_Y[i];  // Measured from the window top
      end
    end
    glyphRow = rowOffset[3:0];
  end

endmodule

// File: verilog/glyphSelect.sv
`timescale 1ns/1ns
`include "clockOverlay_defines.svh"

module glyphSelect (
  input  clockOverlayPkg::slotIdT   slotId,
  input  clockOverlayPkg::charCodeT hourTens,
  input  clockOverlayPkg::charCodeT hourOnes,
  input  clockOverlayPkg::charCodeT minTens,
  input  clockOverlayPkg::charCodeT minOnes,
  input  clockOverlayPkg::charCodeT secTens,
  input  clockOverlayPkg::charCodeT secOnes,
  input  clockOverlayPkg::charCodeT dayTens,
  input  clockOverlayPkg::charCodeT dayOnes,
  input  clockOverlayPkg::charCodeT monTens,
  input  clockOverlayPkg::charCodeT monOnes,
  input  clockOverlayPkg::charCodeT yearTens,
  input  clockOverlayPkg::charCodeT yearOnes,
  input  clockOverlayPkg::charCodeT weekTens,
  input  clockOverlayPkg::charCodeT weekOnes,
  output clockOverlayPkg::charCodeT charCode
);

  always_comb begin
    case (slotId)
      5'd0:    charCode = hourTens;
      5'd1:    charCode = hourOnes;
      5'd2:    charCode = minTens;
      5'd3:    charCode = minOnes;
      5'd4:    charCode = secTens;
      5'd5:    charCode = secOnes;
      5'd6:    charCode = dayTens;
      5'd7:    charCode = dayOnes;
      5'd8:    charCode = monTens;
      5'd9:    charCode = monOnes;
      5'd10:   charCode = `CHAR_2;   // Century prefix
      5'd11:   charCode = `CHAR_0;
      5'd12:   charCode = yearTens;
      5'd13:   charCode = yearOnes;
      5'd14:   charCode = `CHAR_S;   // Week label
      5'd15:   charCode = `CHAR_E;
      5'd16:   charCode = `CHAR_M;
      5'd17:   charCode = `CHAR_A;
      5'd18:   charCode = `CHAR_N;
      5'd19:   charCode = `CHAR_A;
      5'd20:   charCode = weekTens;
      5'd21:   charCode = weekOnes;
      default: charCode = `BLANK_CHAR;  // Unused slot numbers
    endcase
  end

endmodule

// File: verilog/backgroundBands.sv
`timescale 1ns/1ns
`include "clockOverlay_defines.svh"

module backgroundBands (
  input  clockOverlayPkg::pixCoordT pixelY,
  output clockOverlayPkg::colorIdxT bandColor
);

  // First band whose last row is at or above pixelY wins
  always_comb begin
    if (pixelY <= `BAND0_LAST) begin
      bandColor = `BAND0_COLOR;
    end else if (pixelY <= `BAND1_LAST) begin
      bandColor = `BAND1_COLOR;
    end else if (pixelY <= `BAND2_LAST) begin
      bandColor = `BAND2_COLOR;  // Flat card area
    end else if (pixelY <= `BAND3_LAST) begin
      bandColor = `BAND3_COLOR;
    end else if (pixelY <= `BAND4_LAST) begin
      bandColor = `BAND4_COLOR;
    end else if (pixelY <= `BAND5_LAST) begin
      bandColor = `BAND5_COLOR;
    end else if (pixelY <= `BAND6_LAST) begin
      bandColor = `BAND6_COLOR;
    end else if (pixelY <= `BAND7_LAST) begin
      bandColor = `BAND7_COLOR;
    end else begin
      bandColor = `BAND_OUT_COLOR;  // Below the visible raster
    end
  end

endmodule

// File: verilog/pixelSequencer.sv
`timescale 1ns/1ns
`include "clockOverlay_defines.svh"

module pixelSequencer (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      pixStb,
  input  logic                      slotHit,
  input  clockOverlayPkg::charCodeT charCode,
  input  clockOverlayPkg::glyphRowT glyphRow,
  input  clockOverlayPkg::colorIdxT bandColor,
  input  clockOverlayPkg::pixCoordT pixelY,
  output logic                      outStb,
  output logic                      textPixel,
  output clockOverlayPkg::romAddrT  romAddr,
  output clockOverlayPkg::colorIdxT colorIdx
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outStb    <= 1'b0;
      textPixel <= 1'b0;
      romAddr   <= '0;
      colorIdx  <= '0;
    end else begin
      outStb <= pixStb;  // One cycle behind the input strobe
      if (pixStb) begin
        textPixel <= slotHit;
        if (slotHit) begin
          romAddr  <= {charCode, glyphRow};
          colorIdx <= `TEXT_COLOR;
        end else begin
          // Background pixels still walk the blank glyph rows
          romAddr  <= {`BLANK_CHAR, pixelY[3:0]};
          colorIdx <= bandColor;
        end
      end
    end
  end

  // Every output strobe answers an input strobe one cycle earlier
  stbFollowsInput: assert property (
    @(posedge clk) disable iff (!arstN)
    outStb |-> $past(pixStb)
  );

  // Text pixels always carry the text palette entry
  textUsesTextColor: assert property (
    @(posedge clk) disable iff (!arstN)
    textPixel |-> (colorIdx == `TEXT_COLOR)
  );

endmodule

// File: verilog/clockOverlay.sv
`timescale 1ns/1ns

module clockOverlay (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      pixStb,
  input  clockOverlayPkg::pixCoordT pixelX,
  input  clockOverlayPkg::pixCoordT pixelY,
  input  clockOverlayPkg::charCodeT hourTens,
  input  clockOverlayPkg::charCodeT hourOnes,
  input  clockOverlayPkg::charCodeT minTens,
  input  clockOverlayPkg::charCodeT minOnes,
  input  clockOverlayPkg::charCodeT secTens,
  input  clockOverlayPkg::charCodeT secOnes,
  input  clockOverlayPkg::charCodeT dayTens,
  input  clockOverlayPkg::charCodeT dayOnes,
  input  clockOverlayPkg::charCodeT monTens,
  input  clockOverlayPkg::charCodeT monOnes,
  input  clockOverlayPkg::charCodeT yearTens,
  input  clockOverlayPkg::charCodeT yearOnes,
  input  clockOverlayPkg::charCodeT weekTens,
  input  clockOverlayPkg::charCodeT weekOnes,
  output logic                      outStb,
  output logic                      textPixel,
  output clockOverlayPkg::romAddrT  romAddr,
  output clockOverlayPkg::colorIdxT colorIdx
);

  import clockOverlayPkg::*;

  logic     slotHit;
  slotIdT   slotId;
  glyphRowT glyphRow;
  charCodeT charCode;
  colorIdxT bandColor;

  fieldLocator u_fieldLocator (
    .pixelX   (pixelX),
    .pixelY   (pixelY),
    .slotHit  (slotHit),
    .slotId   (slotId),
    .glyphRow (glyphRow)
  );

  glyphSelect u_glyphSelect (
    .slotId   (slotId),
    .hourTens (hourTens),
    .hourOnes (hourOnes),
    .minTens  (minTens),
    .minOnes  (minOnes),
    .secTens  (secTens),
    .secOnes  (secOnes),
    .dayTens  (dayTens),
    .dayOnes  (dayOnes),
    .monTens  (monTens),
    .monOnes  (monOnes),
    .yearTens (yearTens),
    .yearOnes (yearOnes),
    .weekTens (weekTens),
    .weekOnes (weekOnes),
    .charCode (charCode)
  );

  backgroundBands u_backgroundBands (
    .pixelY    (pixelY),
    .bandColor (bandColor)
  );

  pixelSequencer u_pixelSequencer (
    .clk       (clk),
    .arstN     (arstN),
    .pixStb    (pixStb),
    .slotHit   (slotHit),
    .charCode  (charCode),
    .glyphRow  (glyphRow),
    .bandColor (bandColor),
    .pixelY    (pixelY),
    .outStb    (outStb),
    .textPixel (textPixel),
    .romAddr   (romAddr),
    .colorIdx  (colorIdx)
  );

endmodule

// File: testbench/clockOverlayTb.sv
`timescale 1ns/1ns

module clockOverlayTb;

  import clockOverlayPkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ENTRIES = 54;
  localparam int MAX_GAP = 3;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (MAX_GAP + 2) + 20;
  localparam pixCoordT HOLD_X = 10'd350;  // Inside a slot, so a lost hold shows up
  localparam pixCoordT HOLD_Y = 10'd250;

  localparam logic [1:0] CAT_TIME = 2'd0;
  localparam logic [1:0] CAT_DATE = 2'd1;  // Date, year, week and fixed letters
  localparam logic [1:0] CAT_BG = 2'd2;

  // Window layout of the overlay
  localparam int SLOT_X [22] = '{295, 303, 319, 327, 342, 350, 591, 599, 607, 615, 583,
                                 591, 599, 607, 287, 295, 303, 311, 319, 327, 343, 351};
  localparam int SLOT_Y [22] = '{240, 240, 240, 240, 240, 240, 434, 434, 450, 450, 418,
                                 418, 418, 418, 16, 16, 16, 16, 16, 16, 16, 16};
  localparam int BAND_LAST [8] = '{140, 151, 338, 348, 351, 353, 472, 480};
  localparam int BAND_COLOR [8] = '{0, 1, 3, 1, 0, 1, 0, 2};

  typedef struct packed {
    pixCoordT   x;
    pixCoordT   y;
    logic [3:0] gap;       // Idle cycles before this pixel
    logic [1:0] category;
  } stimT;

  localparam stimT STIM [NUM_ENTRIES] = '{
    '{10'd295, 10'd240, 4'd1, CAT_TIME}, '{10'd302, 10'd255, 4'd0, CAT_TIME},
    '{10'd303, 10'd240, 4'd0, CAT_TIME}, '{10'd310, 10'd255, 4'd2, CAT_TIME},
    '{10'd319, 10'd255, 4'd0, CAT_TIME}, '{10'd326, 10'd240, 4'd0, CAT_TIME},
    '{10'd327, 10'd240, 4'd1, CAT_TIME}, '{10'd334, 10'd255, 4'd0, CAT_TIME},
    '{10'd342, 10'd240, 4'd0, CAT_TIME}, '{10'd349, 10'd255, 4'd3, CAT_TIME},
    '{10'd350, 10'd255, 4'd0, CAT_TIME}, '{10'd357, 10'd240, 4'd0, CAT_TIME},
    '{10'd591, 10'd434, 4'd0, CAT_DATE}, '{10'd606, 10'd449, 4'd1, CAT_DATE},
    '{10'd599, 10'd434, 4'd0, CAT_DATE}, '{10'd607, 10'd450, 4'd0, CAT_DATE},
    '{10'd622, 10'd465, 4'd0, CAT_DATE}, '{10'd615, 10'd450, 4'd2, CAT_DATE},
    '{10'd583, 10'd418, 4'd0, CAT_DATE}, '{10'd591, 10'd420, 4'd0, CAT_DATE},
    '{10'd600, 10'd425, 4'd0, CAT_DATE}, '{10'd614, 10'd433, 4'd0, CAT_DATE},
    '{10'd287, 10'd16, 4'd0, CAT_DATE},  '{10'd295, 10'd20, 4'd1, CAT_DATE},
    '{10'd303, 10'd25, 4'd0, CAT_DATE},  '{10'd311, 10'd31, 4'd0, CAT_DATE},
    '{10'd319, 10'd17, 4'd0, CAT_DATE},  '{10'd327, 10'd30, 4'd3, CAT_DATE},
    '{10'd343, 10'd16, 4'd0, CAT_DATE},  '{10'd358, 10'd31, 4'd0, CAT_DATE},
    '{10'd100, 10'd0, 4'd0, CAT_BG},     '{10'd100, 10'd140, 4'd0, CAT_BG},
    '{10'd100, 10'd141, 4'd1, CAT_BG},   '{10'd100, 10'd151, 4'd0, CAT_BG},
    '{10'd100, 10'd152, 4'd0, CAT_BG},   '{10'd100, 10'd338, 4'd2, CAT_BG},
    '{10'd100, 10'd339, 4'd0, CAT_BG},   '{10'd100, 10'd348, 4'd0, CAT_BG},
    '{10'd100, 10'd349, 4'd0, CAT_BG},   '{10'd100, 10'd351, 4'd1, CAT_BG},
    '{10'd100, 10'd352, 4'd0, CAT_BG},   '{10'd100, 10'd353, 4'd0, CAT_BG},
    '{10'd100, 10'd354, 4'd3, CAT_BG},   '{10'd100, 10'd472, 4'd0, CAT_BG},
    '{10'd100, 10'd473, 4'd0, CAT_BG},   '{10'd100, 10'd480, 4'd0, CAT_BG},
    '{10'd100, 10'd481, 4'd1, CAT_BG},   '{10'd100, 10'd600, 4'd0, CAT_BG},
    '{10'd294, 10'd240, 4'd0, CAT_BG},   '{10'd295, 10'd256, 4'd0, CAT_BG},
    '{10'd335, 10'd240, 4'd2, CAT_BG},   '{10'd287, 10'd15, 4'd0, CAT_BG},
    '{10'd359, 10'd16, 4'd0, CAT_BG},    '{10'd583, 10'd434, 4'd0, CAT_BG}
  };

  logic     clk;
  logic     arstN;
  logic     pixStb;
  pixCoordT pixelX;
  pixCoordT pixelY;
  charCodeT digitCode [14];  // Hour, min, sec, day, month, year, week; tens first
  logic     outStb;
  logic     textPixel;
  romAddrT  romAddr;
  colorIdxT colorIdx;

  logic     expStb;
  logic     expText;
  colorIdxT expColor;
  romAddrT  expRom;
  int       catCount [3];

  clockOverlay u_dut (
    .clk       (clk),
    .arstN     (arstN),
    .pixStb    (pixStb),
    .pixelX    (pixelX),
    .pixelY    (pixelY),
    .hourTens  (digitCode[0]),
    .hourOnes  (digitCode[1]),
    .minTens   (digitCode[2]),
    .minOnes   (digitCode[3]),
    .secTens   (digitCode[4]),
    .secOnes   (digitCode[5]),
    .dayTens   (digitCode[6]),
    .dayOnes   (digitCode[7]),
    .monTens   (digitCode[8]),
    .monOnes   (digitCode[9]),
    .yearTens  (digitCode[10]),
    .yearOnes  (digitCode[11]),
    .weekTens  (digitCode[12]),
    .weekOnes  (digitCode[13]),
    .outStb    (outStb),
    .textPixel (textPixel),
    .romAddr   (romAddr),
    .colorIdx  (colorIdx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not reach its end in time");
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  // Character shown in a slot
  function automatic charCodeT slotChar(input int slot);
    string labelText;
    labelText = "SEMANA";
    if (slot <= 9) return digitCode[slot];
    if (slot == 10) return charCodeT'(7'h32);   // "2" of the century
    if (slot == 11) return charCodeT'(7'h30);   // "0" of the century
    if (slot <= 13) return digitCode[slot - 2];
    if (slot <= 19) return charCodeT'(labelText[slot - 14]);
    return digitCode[slot - 8];                 // Week digits
  endfunction

  function automatic colorIdxT bandColorOf(input pixCoordT y);
    for (int b = 0; b < 8; b++) begin
      if (y <= BAND_LAST[b]) return colorIdxT'(BAND_COLOR[b]);
    end
    return 4'd0;  // Below the raster
  endfunction

  task automatic predictPixel(input pixCoordT x, input pixCoordT y);
    int       hit;
    glyphRowT row;
    hit = -1;
    for (int s = 0; s < 22; s++) begin
      if (hit < 0 && x >= SLOT_X[s] && x < SLOT_X[s] + 8 &&
          y >= SLOT_Y[s] && y < SLOT_Y[s] + 16) begin
        hit = s;
      end
    end
    if (hit >= 0) begin
      row      = glyphRowT'(y - SLOT_Y[hit]);
      expText  = 1'b1;
      expColor = 4'd2;
      expRom   = {slotChar(hit), row};
    end else begin
      expText  = 1'b0;
      expColor = bandColorOf(y);
      expRom   = {7'h0A, y[3:0]};  // Blank glyph
    end
  endtask

  task automatic checkValue(input string name, input logic [10:0] expected,
                            input logic [10:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkOutputs();
    checkValue("outStb", expStb, outStb);
    checkValue("textPixel", expText, textPixel);
    checkValue("colorIdx", expColor, colorIdx);
    checkValue("romAddr", expRom, romAddr);
  endtask

  // Checks the last cycle's result, then drives the next one
  task automatic stepCycle(input logic stb, input pixCoordT x, input pixCoordT y);
    @(negedge clk);
    checkOutputs();
    pixStb = stb;
    pixelX = x;
    pixelY = y;
    expStb = stb;
    if (stb) predictPixel(x, y);
  endtask

  initial begin
    void'($urandom(32'h852b115d));
    for (int d = 0; d < 14; d++) begin
      digitCode[d] = charCodeT'(7'h30 + ($urandom % 10));
    end
    arstN    = 1'b0;
    pixStb   = 1'b0;
    pixelX   = '0;
    pixelY   = '0;
    expStb   = 1'b0;
    expText  = 1'b0;
    expColor = '0;
    expRom   = '0;
    catCount = '{0, 0, 0};

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checkOutputs();  // Held clear in reset
    end
    arstN = 1'b1;
    stepCycle(1'b0, HOLD_X, HOLD_Y);
    stepCycle(1'b0, HOLD_X, HOLD_Y);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      repeat (STIM[i].gap) stepCycle(1'b0, HOLD_X, HOLD_Y);
      stepCycle(1'b1, STIM[i].x, STIM[i].y);
      catCount[STIM[i].category]++;
    end
    stepCycle(1'b0, HOLD_X, HOLD_Y);  // Last pixel comes out here
    stepCycle(1'b0, HOLD_X, HOLD_Y);

    $display("Pixels applied: %0d time, %0d date and label, %0d background",
             catCount[0], catCount[1], catCount[2]);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: clockOverlay.f
+incdir+verilog
verilog/clockOverlayPkg.sv
verilog/fieldLocator.sv
verilog/glyphSelect.sv
verilog/backgroundBands.sv
verilog/pixelSequencer.sv
verilog/clockOverlay.sv
testbench/clockOverlayTb.sv
